//--- design/fifo_sync.sv
`timescale 1ns/1ns

module fifo_sync #(
    parameter type DTYPE = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  DTYPE push_data,
    input  logic pop,
    input  logic flush,
    output DTYPE pop_data,
    output logic empty,
    output logic full
);

    // payload storage
    DTYPE mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    // occupancy needs one bit more than the pointers
    logic [$clog2(DEPTH):0]   count;

    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == ($clog2(DEPTH) + 1)'(DEPTH));

    // a push into a full queue is dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // first word fall through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/ooo_core_top.sv
`timescale 1ns/1ns

module ooo_core_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    input  tomasulo_pkg::dispatch_t dispatch,
    output logic                    dispatch_ready,
    input  tomasulo_pkg::cdb_t      cdb,
    output tomasulo_pkg::commit_t   commit,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc,
    output logic                    flush_busy,
    input  logic [4:0]              read_addr,
    output logic [31:0]             read_data,
    output logic                    read_busy,
    output tomasulo_pkg::rob_tag_t  read_tag
);

    // head of the instruction queue
    tomasulo_pkg::dispatch_t iq_head;
    logic                    iq_empty;
    logic                    iq_full;

    logic                    rob_full;
    logic                    alloc_valid;
    tomasulo_pkg::rename_t   rename;
    tomasulo_pkg::squash_t   squash;

    // decode may push while the queue has room
    assign dispatch_ready = ~iq_full;
    // pop and allocation share the same edge
    assign alloc_valid    = ~iq_empty & ~rob_full;

    // queued instructions survive a redirect
    fifo_sync #(
        .DTYPE (tomasulo_pkg::dispatch_t),
        .DEPTH (tomasulo_pkg::iq_depth)
    ) instr_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (dispatch_valid),
        .push_data (dispatch),
        .pop       (alloc_valid),
        .flush     (1'b0),
        .pop_data  (iq_head),
        .empty     (iq_empty),
        .full      (iq_full)
    );

    rob u_rob (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid    (alloc_valid),
        .alloc          (iq_head),
        .cdb            (cdb),
        .rob_full       (rob_full),
        .rename         (rename),
        .commit         (commit),
        .squash         (squash),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush_busy     (flush_busy)
    );

    reg_status u_reg_status (
        .clk       (clk),
        .rst       (rst),
        .rename    (rename),
        .commit    (commit),
        .squash    (squash),
        .read_addr (read_addr),
        .read_data (read_data),
        .read_busy (read_busy),
        .read_tag  (read_tag)
    );

endmodule

//--- design/reg_status.sv
`timescale 1ns/1ns

module reg_status (
    input  logic                   clk,
    input  logic                   rst,
    input  tomasulo_pkg::rename_t  rename,
    input  tomasulo_pkg::commit_t  commit,
    input  tomasulo_pkg::squash_t  squash,
    input  logic [4:0]             read_addr,
    output logic [31:0]            read_data,
    output logic                   read_busy,
    output tomasulo_pkg::rob_tag_t read_tag
);

    // architectural values
    logic [31:0] regs [32];
    // register waits on an in-flight producer
    logic [31:0] busy;
    // ROB tag of the youngest producer
    tomasulo_pkg::rob_tag_t tags [32];

    logic rename_hit;
    logic commit_write;
    logic commit_clear;
    logic squash_clear;

    // x0 never gets a producer
    assign rename_hit = rename.valid & (rename.rd != 5'd0);

    assign commit_write = commit.valid & commit.we & (commit.rd != 5'd0);

    // only the producer that still owns the tag releases the register
    assign commit_clear = commit.valid & commit.we & busy[commit.rd]
                        & (tags[commit.rd] == commit.tag);

    // walk undoes a rename made by a killed entry
    assign squash_clear = squash.valid & busy[squash.rd]
                        & (tags[squash.rd] == squash.tag);

    // architectural state starts at zero, x0 stays there
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_write) begin
            regs[commit.rd] <= commit.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (commit_clear) begin
                busy[commit.rd] <= 1'b0;
            end
            if (squash_clear) begin
                busy[squash.rd] <= 1'b0;
            end
            // rename comes last so it wins over a clear on the same rd
            if (rename_hit) begin
                busy[rename.rd] <= 1'b1;
            end
        end
    end

    // tags only mean something while busy is set
    always_ff @(posedge clk) begin
        if (rename_hit) begin
            tags[rename.rd] <= rename.tag;
        end
    end

    // read port for the outside
    assign read_data = regs[read_addr];
    assign read_busy = busy[read_addr];
    assign read_tag  = tags[read_addr];

endmodule

//--- design/rob.sv
`timescale 1ns/1ns

module rob (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_valid,
    input  tomasulo_pkg::dispatch_t alloc,
    input  tomasulo_pkg::cdb_t      cdb,
    output logic                    rob_full,
    output tomasulo_pkg::rename_t   rename,
    output tomasulo_pkg::commit_t   commit,
    output tomasulo_pkg::squash_t   squash,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc,
    output logic                    flush_busy
);

    // per entry payload
    tomasulo_pkg::op_t ent_op    [tomasulo_pkg::rob_depth];
    logic [4:0]        ent_rd    [tomasulo_pkg::rob_depth];
    logic [31:0]       ent_pc    [tomasulo_pkg::rob_depth];
    logic              ent_pred  [tomasulo_pkg::rob_depth];
    logic [31:0]       ent_value [tomasulo_pkg::rob_depth];
    logic              ent_taken [tomasulo_pkg::rob_depth];
    // result has arrived on the CDB
    logic [tomasulo_pkg::rob_depth-1:0] ent_done;

    tomasulo_pkg::rob_ptr_t head;
    tomasulo_pkg::rob_ptr_t tail;
    tomasulo_pkg::rob_ptr_t count;
    tomasulo_pkg::rob_tag_t head_idx;
    tomasulo_pkg::rob_tag_t tail_idx;
    // walk position, steps from the youngest entry toward the head
    tomasulo_pkg::rob_tag_t flush_ptr;
    // distances from the head
    tomasulo_pkg::rob_tag_t cdb_off;
    tomasulo_pkg::rob_tag_t walk_off;

    logic rob_empty;
    logic alloc_fire;
    logic commit_fire;
    logic mispredict;
    logic no_younger;
    logic walk_last;
    logic cdb_live;

    // branch tags in program order
    logic                   br_push;
    logic                   br_pop;
    logic                   br_flush;
    logic                   br_empty;
    tomasulo_pkg::rob_tag_t br_front;

    // stores and branches leave the register file alone
    function automatic logic writes_reg(tomasulo_pkg::op_t op);
        return (op != tomasulo_pkg::op_store) && (op != tomasulo_pkg::op_branch);
    endfunction

    assign head_idx  = head[tomasulo_pkg::rob_tag_w-1:0];
    assign tail_idx  = tail[tomasulo_pkg::rob_tag_w-1:0];
    assign count     = tail - head;
    assign rob_empty = (count == '0);

    // oldest in-flight branch sits at the head, is resolved and went the other way
    assign mispredict = ~rob_empty & ~flush_busy & ~br_empty
                      & (br_front == head_idx) & ent_done[head_idx]
                      & (ent_taken[head_idx] != ent_pred[head_idx]);
    assign redirect_valid = mispredict;
    // fall-through address of the branch
    assign redirect_pc    = ent_pc[head_idx] + 32'd4;

    // the branch itself is the only entry left
    assign no_younger = (count == tomasulo_pkg::rob_ptr_t'(1));
    assign walk_last  = flush_busy & (flush_ptr == head_idx);

    // hold the queue while full, redirecting or walking
    assign rob_full   = (count == tomasulo_pkg::rob_ptr_t'(tomasulo_pkg::rob_depth))
                      | mispredict | flush_busy;
    assign alloc_fire = alloc_valid & ~rob_full;

    // drop broadcasts to slots that are free, squashed or about to be
    assign cdb_off  = cdb.tag - head_idx;
    assign walk_off = flush_ptr - head_idx;
    assign cdb_live = cdb.valid & ~mispredict & ({1'b0, cdb_off} < count)
                    & ~(flush_busy & (cdb_off >= walk_off));

    // retirement straight from the head state
    always_comb begin
        commit.valid = ~rob_empty & ent_done[head_idx] & ~flush_busy;
        commit.tag   = head_idx;
        commit.op    = ent_op[head_idx];
        commit.rd    = ent_rd[head_idx];
        commit.value = ent_value[head_idx];
        commit.we    = writes_reg(ent_op[head_idx]);
    end
    assign commit_fire = commit.valid;

    // new tag for rd goes to the register status
    assign rename.valid = alloc_fire & writes_reg(alloc.op);
    assign rename.rd    = alloc.rd;
    assign rename.tag   = tail_idx;

    // one squash per walk cycle, youngest first
    assign squash.valid = flush_busy;
    assign squash.tag   = flush_ptr;
    assign squash.rd    = ent_rd[flush_ptr];

    assign br_push  = alloc_fire & (alloc.op == tomasulo_pkg::op_branch);
    assign br_pop   = commit_fire & (ent_op[head_idx] == tomasulo_pkg::op_branch);
    // younger branches die with the walk
    assign br_flush = walk_last | (mispredict & no_younger);

    fifo_sync #(
        .DTYPE (tomasulo_pkg::rob_tag_t),
        .DEPTH (tomasulo_pkg::br_q_depth)
    ) branch_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (br_push),
        .push_data (tail_idx),
        .pop       (br_pop),
        .flush     (br_flush),
        .pop_data  (br_front),
        .empty     (br_empty),
        .full      ()
    );

    // entry payload, written at allocation and by the CDB
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent_op[tail_idx]   <= alloc.op;
            ent_rd[tail_idx]   <= alloc.rd;
            ent_pc[tail_idx]   <= alloc.pc;
            ent_pred[tail_idx] <= alloc.pred_taken;
        end
        if (cdb_live) begin
            ent_value[cdb.tag] <= cdb.value;
            // actual direction, only meaningful for branches
            ent_taken[cdb.tag] <= cdb.taken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            flush_ptr  <= '0;
            flush_busy <= 1'b0;
            ent_done   <= '0;
        end else begin
            if (cdb_live) begin
                ent_done[cdb.tag] <= 1'b1;
            end
            if (alloc_fire) begin
                ent_done[tail_idx] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            if (commit_fire) begin
                ent_done[head_idx] <= 1'b0;
                head               <= head + 1'b1;
            end
            // start the walk at the youngest entry
            if (mispredict && !no_younger) begin
                flush_busy <= 1'b1;
                flush_ptr  <= tail_idx - 1'b1;
            end
            if (flush_busy) begin
                ent_done[flush_ptr] <= 1'b0;
                flush_ptr           <= flush_ptr - 1'b1;
                // last younger entry gone, ROB is empty again
                if (walk_last) begin
                    flush_busy <= 1'b0;
                    tail       <= head;
                end
            end
        end
    end

endmodule

//--- design/tomasulo_pkg.sv
package tomasulo_pkg;

    // reorder buffer size and the tag width that follows from it
    localparam int rob_depth = 8;
    localparam int rob_tag_w = $clog2(rob_depth);

    // decoded instructions waiting for a ROB slot
    localparam int iq_depth = 4;
    // one slot for every branch that can be in flight
    localparam int br_q_depth = 8;

    typedef logic [rob_tag_w-1:0] rob_tag_t;
    // head and tail carry one extra wrap bit on top
    typedef logic [rob_tag_w:0] rob_ptr_t;

    // instruction class as seen by the ROB
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jump
    } op_t;

    // instruction handed over by decode
    typedef struct packed {
        op_t         op;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic        pred_taken;
    } dispatch_t;

    // common data bus broadcast, valid for one cycle
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] value;
        logic        taken;
    } cdb_t;

    // in-order retirement of the head entry
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        op_t         op;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        we;
    } commit_t;

    // one entry killed by the walk
    typedef struct packed {
        logic       valid;
        rob_tag_t   tag;
        logic [4:0] rd;
    } squash_t;

    // new producer of rd at allocation
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        rob_tag_t   tag;
    } rename_t;

endpackage

//--- flist.f
design/tomasulo_pkg.sv
design/fifo_sync.sv
design/rob.sv
design/reg_status.sv
design/ooo_core_top.sv
tb/rob_checker.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f flist.f -o sim_tb || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1

//--- tb/rob_checker.sv
`timescale 1ns/1ns

module rob_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   rob_full,
    input tomasulo_pkg::rob_ptr_t head,
    input tomasulo_pkg::rob_ptr_t tail,
    input tomasulo_pkg::commit_t  commit,
    input logic                   redirect_valid,
    input logic                   flush_busy
);

    // no retirement while the walk is running so the head stays put
    commit_not_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush_busy |=> (head == $past(head)))
        else $error("head moved while the squash walk is running");

    // a full or redirecting ROB takes no new entry
    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        (rob_full && !flush_busy) |=> (tail == $past(tail)))
        else $error("allocation while the ROB is full");

    // redirect is a single cycle pulse
    redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else $error("redirect held for more than one cycle");

    // control outputs come up quiet
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!commit.valid && !redirect_valid && !flush_busy))
        else $error("control output active right after reset");

endmodule

bind rob rob_checker u_rob_checker (.*);

//--- tb/rob_stim.txt
# D op rd pc pred | C tag value taken | L tag taken (lfsr value) | W cycles
# R addr value busy tag | T name ; op 0 alu 1 load 2 store 3 branch 4 jump
T out_of_order
D 0 1 00000100 0
D 0 2 00000104 0
D 0 3 00000108 0
W 4
C 2 00000033 0
C 0 00000011 0
C 1 00000022 0
W 8
R 1 00000011 0 0
R 2 00000022 0
R 3 00000033 0 0
T store_branch
D 2 5 0000010c 0
D 3 0 00000110 1
D 0 0 00000114 0
W 4
C 3 0000dead 0
C 4 00000000 1
C 5 00001234 0
W 8
R 5 00000000 0 0
R 0 00000000 0 0
T backpressure
D 0 10 00000120 0
D 0 11 00000124 0
D 0 12 00000128 0
D 0 13 0000012c 0
D 0 14 00000130 0
D 0 15 00000134 0
D 0 16 00000138 0
D 0 17 0000013c 0
D 0 18 00000140 0
D 0 19 00000144 0
W 4
L 7 0
L 6 0
L 1 0
L 0 0
L 3 0
L 2 0
L 5 0
L 4 0
W 6
C 7 00000919 0
C 6 00000818 0
W 8
R 18 00000818 0 0
R 19 00000919 0 0
T mispredict
D 0 20 00000200 0
D 3 0 00000204 0
D 0 21 00000208 0
D 0 22 0000020c 0
D 3 0 00000210 1
W 4
C 0 00000500 0
C 2 00000777 0
W 2
C 1 00000000 1
W 10
C 3 00000999 0
W 4
R 20 00000500 0 0
R 21 00000000 0 0
R 22 00000000 0 0
T after_flush
D 0 23 00000300 0
D 3 0 00000304 1
W 4
C 3 00000000 1
C 2 00000abc 0
W 8
R 23 00000abc 0 0
T same_rd
D 0 7 00000400 0
D 0 7 00000404 0
W 4
C 4 00000111 0
W 4
R 7 00000111 1 5
C 5 00000222 0
W 4
R 7 00000222 0 0
W 4

//--- tb/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    logic                    clk;
    logic                    rst;
    logic                    dispatch_valid;
    tomasulo_pkg::dispatch_t dispatch;
    logic                    dispatch_ready;
    tomasulo_pkg::cdb_t      cdb;
    tomasulo_pkg::commit_t   commit;
    logic                    redirect_valid;
    logic [31:0]             redirect_pc;
    logic                    flush_busy;
    logic [4:0]              read_addr;
    logic [31:0]             read_data;
    logic                    read_busy;
    tomasulo_pkg::rob_tag_t  read_tag;

    // reference model indexed by program order
    int          m_tag [64];
    int          m_op [64];
    logic [4:0]  m_rd [64];
    logic [31:0] m_pc [64];
    logic        m_pred [64];
    logic [31:0] m_val [64];
    logic        m_taken [64];
    logic        m_done [64];
    // entries neither committed nor squashed in age order
    int          live [$];
    int          n_seq;
    int          next_tag;
    // walk cycles still expected after a mispredict
    int          flush_left;

    logic [31:0]  lfsr;
    logic [127:0] test_name;
    int errors;
    int test_err0;
    int n_pass;
    int n_fail;
    int limit;
    logic test_open;

    ooo_core_top u_ooo_core_top (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch %0s %0s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic require_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("Error in %0s: %0s", test_name, msg);
            errors++;
        end
    endtask

    task automatic close_test();
        if (test_open) begin
            if (errors == test_err0) begin
                $display("test %0s: ok", test_name);
                n_pass++;
            end else begin
                $display("test %0s: %0d errors", test_name, errors - test_err0);
                n_fail++;
            end
        end
    endtask

    // commit stream is compared with the model before the edge updates state
    always @(posedge clk) begin
        int s;
        if (!rst) begin
            // one walk cycle per squashed entry
            compare_value("flush_busy", flush_left > 0, flush_busy);
            if (flush_left > 0) begin
                flush_left--;
            end
        end
        if (!rst && commit.valid) begin
            if (live.size() == 0) begin
                require_true(1'b0, "commit with no instruction outstanding");
            end else begin
                s = live.pop_front();
                require_true(m_done[s], "commit before the result was broadcast");
                compare_value("commit tag", m_tag[s], commit.tag);
                compare_value("commit op", m_op[s], commit.op);
                compare_value("commit rd", m_rd[s], commit.rd);
                compare_value("commit value", m_val[s], commit.value);
                compare_value("commit we", (m_op[s] != 2) && (m_op[s] != 3), commit.we);
                if (m_op[s] == 3 && m_taken[s] != m_pred[s]) begin
                    compare_value("redirect", 1, redirect_valid);
                    compare_value("redirect pc", m_pc[s] + 32'd4, redirect_pc);
                    // every younger entry is squashed and the tail falls back behind the branch
                    flush_left = live.size();
                    live.delete();
                    next_tag = (m_tag[s] + 1) % tomasulo_pkg::rob_depth;
                end else begin
                    compare_value("redirect", 0, redirect_valid);
                end
            end
        end else if (!rst) begin
            compare_value("redirect", 0, redirect_valid);
        end
    end

    // runs out after the budget taken from the stimulus file
    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("Error: simulation timed out after %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int fd;
        int code;
        int a;
        int b;
        int c;
        int d;
        logic [31:0] v;
        byte cmd;
        string line;

        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        cdb = '0;
        read_addr = '0;
        lfsr = 32'h3ca1_2260;
        test_name = "reset";
        errors = 0;
        test_err0 = 0;
        n_pass = 0;
        n_fail = 0;
        n_seq = 0;
        next_tag = 0;
        flush_left = 0;
        test_open = 1'b0;

        // first pass sums the waits and counts operations for the watchdog
        fd = $fopen("tb/rob_stim.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open tb/rob_stim.txt");
            errors++;
        end
        limit = 64;
        while (fd != 0 && $fscanf(fd, " %c", cmd) == 1) begin
            code = $fgets(line, fd);
            if (cmd == "W") begin
                code = $sscanf(line, "%d", a);
                limit += a;
            end else if (cmd != "#") begin
                limit += 64;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        repeat (4) @(negedge clk);
        rst = 1'b0;
        compare_value("dispatch_ready", 1, dispatch_ready);

        fd = $fopen("tb/rob_stim.txt", "r");
        while (fd != 0 && $fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "D": begin
                    code = $fscanf(fd, "%d %d %h %d", a, b, v, c);
                    // a full queue drops the push, so hold back until it has room
                    while (!dispatch_ready) @(negedge clk);
                    dispatch_valid = 1'b1;
                    dispatch.op = tomasulo_pkg::op_t'(a);
                    dispatch.rd = b[4:0];
                    dispatch.pc = v;
                    dispatch.pred_taken = c[0];
                    m_tag[n_seq] = next_tag;
                    m_op[n_seq] = a;
                    m_rd[n_seq] = b[4:0];
                    m_pc[n_seq] = v;
                    m_pred[n_seq] = c[0];
                    m_done[n_seq] = 1'b0;
                    live.push_back(n_seq);
                    n_seq++;
                    next_tag = (next_tag + 1) % tomasulo_pkg::rob_depth;
                    @(negedge clk);
                    dispatch_valid = 1'b0;
                end
                "C", "L": begin
                    if (cmd == "C") begin
                        code = $fscanf(fd, "%d %h %d", a, v, c);
                    end else begin
                        code = $fscanf(fd, "%d %d", a, c);
                        for (int i = 0; i < 32; i++) begin
                            v = {v[30:0], lfsr[0]};
                            lfsr = lfsr_next(lfsr);
                        end
                    end
                    cdb.valid = 1'b1;
                    cdb.tag = a[2:0];
                    cdb.value = v;
                    cdb.taken = c[0];
                    // the oldest live entry with that tag takes it while squashed tags match nothing
                    foreach (live[i]) begin
                        if (m_tag[live[i]] == a && !m_done[live[i]]) begin
                            m_done[live[i]] = 1'b1;
                            m_val[live[i]] = v;
                            m_taken[live[i]] = c[0];
                            break;
                        end
                    end
                    @(negedge clk);
                    cdb = '0;
                end
                "W": begin
                    code = $fscanf(fd, "%d", a);
                    repeat (a) @(negedge clk);
                end
                "R": begin
                    code = $fscanf(fd, "%d %h %d %d", a, v, b, d);
                    read_addr = a[4:0];
                    @(negedge clk);
                    compare_value("read data", v, read_data);
                    compare_value("read busy", b, read_busy);
                    if (b != 0) begin
                        compare_value("read tag", d, read_tag);
                    end
                end
                "T": begin
                    close_test();
                    code = $fscanf(fd, "%s", test_name);
                    test_err0 = errors;
                    test_open = 1'b1;
                end
                default: begin
                    code = $fgets(line, fd);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        require_true(live.size() == 0, "instructions left that never committed");
        close_test();
        $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
